//--- logic/loader_cfg.svh
// Media loader configuration
// Widths, RAM map, download index codes and mount slot numbers
`ifndef LOADER_CFG_SVH
`define LOADER_CFG_SVH

// ==============================
// Widths
// ==============================
`define LOADER_ADDR_W      27
`define LOADER_HALF_W      16
`define LOADER_WORD_W      32
`define LOADER_BE_W        4
`define LOADER_INDEX_W     8
`define LOADER_CD_SIZE_W   30
`define LOADER_IMG_SIZE_W  64
`define LOADER_SLOT_N      4

// ==============================
// RAM map
// ==============================
`define LOADER_BIOS_BASE   2097152
`define LOADER_EXE_BASE    4194304
`define LOADER_CD_BASE     0

// Host download index codes, CD only looks at the low 6 bits
`define LOADER_IDX_BIOS    8'd0
`define LOADER_IDX_EXE     8'd1
`define LOADER_IDX_CD      6'd2

// Mount slots
`define LOADER_SLOT_CD     1
`define LOADER_SLOT_CARD1  2
`define LOADER_SLOT_CARD2  3

`endif

//--- logic/loader_pkg.sv
// Media loader types
// Download kind, host beat, RAM write and mount status records
`include "loader_cfg.svh"

package loader_pkg;

	// ==============================
	// Download classification
	// ==============================
	typedef enum logic [1:0] {
		dl_none = 2'd0,
		dl_bios = 2'd1,
		dl_exe  = 2'd2,
		dl_cd   = 2'd3
	} dl_kind_e;

	// ==============================
	// Write paths
	// ==============================

	// One 16-bit beat from the host
	typedef struct packed {
		logic [`LOADER_ADDR_W-1:0] addr;
		logic [`LOADER_HALF_W-1:0] data;
	} dl_word_t;

	// One 32-bit write towards the RAM
	typedef struct packed {
		logic [`LOADER_ADDR_W-1:0] addr;
		logic [`LOADER_WORD_W-1:0] data;
		logic [`LOADER_BE_W-1:0]   be;
	} ram_wr_t;

	// ==============================
	// Media state
	// ==============================

	// cd_from_sd low means the image came through a host download
	typedef struct packed {
		logic                         has_cd;
		logic                         cd_from_sd;
		logic [`LOADER_CD_SIZE_W-1:0] cd_size;
		logic                         card1_present;
		logic                         card2_present;
	} media_status_t;

	// Levels from the menu
	typedef struct packed {
		logic load_req;
		logic save_req;
		logic autosave;
		logic osd_open;
	} media_req_t;

endpackage

//--- logic/download_packer.sv
// Host download packer
// Classifies the download, joins 16-bit beats into 32-bit RAM writes
// and holds the host until the RAM has taken each write
`timescale 1ns/1ps
`include "loader_cfg.svh"

module download_packer (
	input  logic                         clk_1x,
	input  logic                         arst_n,
	input  logic                         dl_active,
	input  logic [`LOADER_INDEX_W-1:0]   dl_index,
	input  logic                         dl_wr,
	input  loader_pkg::dl_word_t         dl_beat,
	input  logic                         dl_wr_ack,
	output logic                         dl_wait,
	output logic                         dl_owner,
	output logic                         pack_req,
	output loader_pkg::ram_wr_t          pack_wr,
	output logic                         exe_loaded,
	output logic                         cd_dl_done,
	output logic [`LOADER_CD_SIZE_W-1:0] cd_dl_size
);
	import loader_pkg::*;

	dl_kind_e                  dl_kind;
	dl_kind_e                  kind_d;
	dl_kind_e                  kind_next;
	logic [`LOADER_ADDR_W-1:0] pend_addr;
	logic [`LOADER_HALF_W-1:0] pend_low;
	logic [`LOADER_ADDR_W-1:0] last_addr;
	logic                      lower_beat;
	logic                      upper_beat;
	logic                      exe_end;
	logic                      cd_end;

	// RAM offset of each download kind
	function automatic logic [`LOADER_ADDR_W-1:0] kind_base(input dl_kind_e kind);
		case (kind)
			dl_bios: return `LOADER_ADDR_W'(`LOADER_BIOS_BASE);
			dl_exe:  return `LOADER_ADDR_W'(`LOADER_EXE_BASE);
			default: return `LOADER_ADDR_W'(`LOADER_CD_BASE);
		endcase
	endfunction

	// ==============================
	// Classification
	// ==============================
	always_comb begin
		kind_next = dl_none;
		if (dl_active) begin
			if (dl_index == `LOADER_IDX_BIOS)
				kind_next = dl_bios;
			else if (dl_index == `LOADER_IDX_EXE)
				kind_next = dl_exe;
			else if (dl_index[5:0] == `LOADER_IDX_CD)
				kind_next = dl_cd;
		end
	end

	assign dl_owner   = (dl_kind != dl_none);
	assign lower_beat = dl_wr && dl_owner && !dl_beat.addr[1];
	assign upper_beat = dl_wr && dl_owner && dl_beat.addr[1];

	// Falling edge of each download kind
	assign exe_end = (kind_d == dl_exe) && (dl_kind != dl_exe);
	assign cd_end  = (kind_d == dl_cd) && (dl_kind != dl_cd);

	// ==============================
	// Control
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			dl_kind    <= dl_none;
			kind_d     <= dl_none;
			dl_wait    <= 1'b0;
			pack_req   <= 1'b0;
			exe_loaded <= 1'b0;
			cd_dl_done <= 1'b0;
		end else begin
			dl_kind    <= kind_next;
			kind_d     <= dl_kind;
			pack_req   <= upper_beat;
			exe_loaded <= exe_end;
			cd_dl_done <= cd_end;
			// Hold the host from the completed word until its acknowledge
			if (!dl_owner)
				dl_wait <= 1'b0;
			else if (upper_beat)
				dl_wait <= 1'b1;
			else if (dl_wr_ack)
				dl_wait <= 1'b0;
		end
	end

	// ==============================
	// Word assembly
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (dl_wr && dl_owner)
			last_addr <= dl_beat.addr;
		if (lower_beat) begin
			pend_addr <= dl_beat.addr + kind_base(dl_kind);
			pend_low  <= dl_beat.data;
		end
		// Upper half completes the word, always a full 32-bit write
		if (upper_beat) begin
			pack_wr.addr <= pend_addr;
			pack_wr.data <= {dl_beat.data, pend_low};
			pack_wr.be   <= '1;
		end
		if (cd_end)
			cd_dl_size <= `LOADER_CD_SIZE_W'(last_addr);
	end

endmodule

//--- logic/ram_write_mux.sv
// RAM write port arbiter
// Downloads own the port while active, the core gets it otherwise
`timescale 1ns/1ps

module ram_write_mux (
	input  logic                clk_1x,
	input  logic                arst_n,
	input  logic                dl_owner,
	input  logic                pack_req,
	input  loader_pkg::ram_wr_t pack_wr,
	input  logic                core_wr,
	input  loader_pkg::ram_wr_t core_req,
	input  logic                ram_wr_ack,
	output logic                ram_wr_req,
	output loader_pkg::ram_wr_t ram_wr,
	output logic                dl_wr_ack,
	output logic                core_wr_ack
);

	logic sel_req;

	// Core writes during a download are dropped here
	assign sel_req = dl_owner ? pack_req : core_wr;

	// ==============================
	// Strobes
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			ram_wr_req  <= 1'b0;
			dl_wr_ack   <= 1'b0;
			core_wr_ack <= 1'b0;
		end else begin
			ram_wr_req <= sel_req;
			// Acknowledge goes to whoever owns the port when it arrives
			dl_wr_ack   <= ram_wr_ack & dl_owner;
			core_wr_ack <= ram_wr_ack & ~dl_owner;
		end
	end

	// ==============================
	// Write payload
	// ==============================
	always_ff @(posedge clk_1x) begin
		if (sel_req) begin
			if (dl_owner)
				ram_wr <= pack_wr;
			else
				ram_wr <= core_req;
		end
	end

endmodule

//--- logic/media_tracker.sv
// Media mount tracker
// Keeps CD and memory card state, makes the card load and save strobes
`timescale 1ns/1ps
`include "loader_cfg.svh"

module media_tracker (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	input  logic [`LOADER_SLOT_N-1:0]     img_mounted,
	input  logic [`LOADER_IMG_SIZE_W-1:0] img_size,
	input  logic                          cd_dl_done,
	input  logic [`LOADER_CD_SIZE_W-1:0]  cd_dl_size,
	input  loader_pkg::media_req_t        user_req,
	output loader_pkg::media_status_t     media,
	output logic                          card1_load,
	output logic                          card2_load,
	output logic                          card_save
);
	import loader_pkg::*;

	media_req_t req_q;
	logic       load_q;
	logic       save_q;
	logic       auto_q;
	logic       auto_save;
	logic       load_rise;
	logic       save_rise;
	logic       img_nonzero;
	logic       card1_mount;
	logic       card2_mount;

	assign img_nonzero = (img_size != '0);
	assign card1_mount = img_mounted[`LOADER_SLOT_CARD1] & img_nonzero;
	assign card2_mount = img_mounted[`LOADER_SLOT_CARD2] & img_nonzero;

	// Autosave fires when the menu opens
	assign auto_save = req_q.osd_open & req_q.autosave;
	assign load_rise = req_q.load_req & ~load_q;
	assign save_rise = (req_q.save_req & ~save_q) | (auto_save & ~auto_q);

	// ==============================
	// Mount state
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			media <= '0;
		end else begin
			// Host download first, a mount in the same cycle wins
			if (cd_dl_done) begin
				media.has_cd     <= 1'b1;
				media.cd_from_sd <= 1'b0;
				media.cd_size    <= cd_dl_size;
			end
			if (img_mounted[`LOADER_SLOT_CD]) begin
				if (img_nonzero) begin
					media.has_cd     <= 1'b1;
					media.cd_from_sd <= 1'b1;
					media.cd_size    <= img_size[`LOADER_CD_SIZE_W-1:0];
				end else begin
					media.has_cd <= 1'b0;
				end
			end
			if (img_mounted[`LOADER_SLOT_CARD1])
				media.card1_present <= img_nonzero;
			if (img_mounted[`LOADER_SLOT_CARD2])
				media.card2_present <= img_nonzero;
		end
	end

	// ==============================
	// Load and save strobes
	// ==============================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			req_q      <= '0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			auto_q     <= 1'b0;
			card1_load <= 1'b0;
			card2_load <= 1'b0;
			card_save  <= 1'b0;
		end else begin
			// Menu levels are sampled once before edge detection
			req_q      <= user_req;
			load_q     <= req_q.load_req;
			save_q     <= req_q.save_req;
			auto_q     <= auto_save;
			card1_load <= card1_mount | load_rise;
			card2_load <= card2_mount | load_rise;
			card_save  <= save_rise;
		end
	end

endmodule

//--- logic/loader_top.sv
// Media loader top level
// Download packing, RAM write arbitration and media bookkeeping
`timescale 1ns/1ps
`include "loader_cfg.svh"

module loader_top (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	input  logic                          dl_active,
	input  logic [`LOADER_INDEX_W-1:0]    dl_index,
	input  logic                          dl_wr,
	input  loader_pkg::dl_word_t          dl_beat,
	input  logic                          core_wr,
	input  loader_pkg::ram_wr_t           core_req,
	input  logic [`LOADER_SLOT_N-1:0]     img_mounted,
	input  logic [`LOADER_IMG_SIZE_W-1:0] img_size,
	input  loader_pkg::media_req_t        user_req,
	input  logic                          ram_wr_ack,
	output logic                          ram_wr_req,
	output loader_pkg::ram_wr_t           ram_wr,
	output logic                          dl_wait,
	output logic                          core_wr_ack,
	output logic                          core_hold,
	output logic                          exe_loaded,
	output logic                          card1_load,
	output logic                          card2_load,
	output logic                          card_save,
	output loader_pkg::media_status_t     media
);
	import loader_pkg::*;

	ram_wr_t                      pack_wr;
	logic                         pack_req;
	logic                         dl_owner;
	logic                         dl_wr_ack;
	logic                         cd_dl_done;
	logic [`LOADER_CD_SIZE_W-1:0] cd_dl_size;

	// Core stays in reset for the whole download
	assign core_hold = dl_owner;

	download_packer download_packer_inst (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.dl_active  (dl_active),
		.dl_index   (dl_index),
		.dl_wr      (dl_wr),
		.dl_beat    (dl_beat),
		.dl_wr_ack  (dl_wr_ack),
		.dl_wait    (dl_wait),
		.dl_owner   (dl_owner),
		.pack_req   (pack_req),
		.pack_wr    (pack_wr),
		.exe_loaded (exe_loaded),
		.cd_dl_done (cd_dl_done),
		.cd_dl_size (cd_dl_size)
	);

	ram_write_mux ram_write_mux_inst (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.dl_owner    (dl_owner),
		.pack_req    (pack_req),
		.pack_wr     (pack_wr),
		.core_wr     (core_wr),
		.core_req    (core_req),
		.ram_wr_ack  (ram_wr_ack),
		.ram_wr_req  (ram_wr_req),
		.ram_wr      (ram_wr),
		.dl_wr_ack   (dl_wr_ack),
		.core_wr_ack (core_wr_ack)
	);

	media_tracker media_tracker_inst (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.img_mounted (img_mounted),
		.img_size    (img_size),
		.cd_dl_done  (cd_dl_done),
		.cd_dl_size  (cd_dl_size),
		.user_req    (user_req),
		.media       (media),
		.card1_load  (card1_load),
		.card2_load  (card2_load),
		.card_save   (card_save)
	);

endmodule

//--- testbench/loader_assertions.sv
// Media loader handshake checks
// Bound into the loader top level
`timescale 1ns/1ps

module loader_assertions (
	input logic                clk_1x,
	input logic                arst_n,
	input logic                dl_owner,
	input logic                ram_wr_req,
	input loader_pkg::ram_wr_t ram_wr,
	input logic                ram_wr_ack,
	input logic                dl_wr_ack,
	input logic                core_wr_ack,
	input logic                dl_wait,
	input logic                exe_loaded,
	input logic                card1_load,
	input logic                card2_load,
	input logic                card_save
);

	int fail_count = 0;

	// Download writes are always full words
	full_word_a: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(ram_wr_req && dl_owner) |-> (ram_wr.be == 4'hf))
		else begin
			fail_count++;
			$error("Download write reached RAM without all byte enables");
		end

	// ==============================
	// Acknowledge routing
	// ==============================
	ack_route_a: assert property (@(posedge clk_1x) disable iff (!arst_n)
		ram_wr_ack |=> (dl_wr_ack ^ core_wr_ack))
		else begin
			fail_count++;
			$error("RAM acknowledge not passed on one cycle later");
		end
	dl_ack_a: assert property (@(posedge clk_1x) disable iff (!arst_n)
		dl_wr_ack |-> $past(ram_wr_ack))
		else begin
			fail_count++;
			$error("Download acknowledge without a RAM acknowledge");
		end
	core_ack_a: assert property (@(posedge clk_1x) disable iff (!arst_n)
		core_wr_ack |-> $past(ram_wr_ack))
		else begin
			fail_count++;
			$error("Core acknowledge without a RAM acknowledge");
		end

	// Everything quiet while reset is held
	reset_quiet_a: assert property (@(posedge clk_1x)
		!arst_n |-> !(ram_wr_req || dl_wr_ack || core_wr_ack || dl_wait || exe_loaded
			|| card1_load || card2_load || card_save))
		else begin
			fail_count++;
			$error("Strobe high during reset");
		end

endmodule

bind loader_top loader_assertions loader_assertions_inst (
	.clk_1x      (clk_1x),
	.arst_n      (arst_n),
	.dl_owner    (dl_owner),
	.ram_wr_req  (ram_wr_req),
	.ram_wr      (ram_wr),
	.ram_wr_ack  (ram_wr_ack),
	.dl_wr_ack   (dl_wr_ack),
	.core_wr_ack (core_wr_ack),
	.dl_wait     (dl_wait),
	.exe_loaded  (exe_loaded),
	.card1_load  (card1_load),
	.card2_load  (card2_load),
	.card_save   (card_save)
);

//--- testbench/loader_tb.sv
// Media loader testbench
// Table driven downloads, core writes, mounts and memory card requests
`timescale 1ns/1ps
`include "loader_cfg.svh"

module loader_tb;
	import loader_pkg::*;

	typedef enum logic [2:0] {op_dl_word, op_core_wr, op_mount, op_load, op_save, op_dl_end} op_e;
	typedef enum int {w_ram_req, w_core_ack, w_wait_low, w_exe, w_card1, w_save, w_hold,
		w_hold_low} wait_e;

	// sel is the byte enable, mount slot or autosave flag depending on op
	typedef struct packed {
		op_e                       op;
		logic [7:0]                index;
		logic [`LOADER_ADDR_W-1:0] addr;
		logic [31:0]               data;
		logic [63:0]               size;
		logic [3:0]                sel;
	} row_t;

	localparam int N_ROWS      = 16;
	localparam int CYCLE_LIMIT = 8 + 20 * N_ROWS;
	localparam int WAIT_LIMIT  = 20;

	logic                      clk_1x = 1'b0;
	logic                      arst_n;
	logic                      dl_active;
	logic [7:0]                dl_index;
	logic                      dl_wr;
	dl_word_t                  dl_beat;
	logic                      core_wr;
	ram_wr_t                   core_req;
	logic [3:0]                img_mounted;
	logic [63:0]               img_size;
	media_req_t                user_req;
	logic                      ram_wr_ack;
	logic                      ram_wr_req;
	ram_wr_t                   ram_wr;
	logic                      dl_wait;
	logic                      core_wr_ack;
	logic                      core_hold;
	logic                      exe_loaded;
	logic                      card1_load;
	logic                      card2_load;
	logic                      card_save;
	media_status_t             media;
	row_t                      rows [N_ROWS];
	media_status_t             exp_media;
	logic [2:0]                ack_pipe;
	logic                      dl_on;
	logic [`LOADER_ADDR_W-1:0] last_host_addr;
	int                        cycle_count = 0;

	loader_top loader_top_inst (.*);

	always #20 clk_1x = ~clk_1x;

	// ==============================
	// RAM model acknowledging 3 cycles after each request
	// ==============================
	always @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n)
			ack_pipe <= '0;
		else
			ack_pipe <= {ack_pipe[1:0], ram_wr_req};
	end

	always @(posedge clk_1x) begin
		#2 ram_wr_ack = ack_pipe[2];
	end

	always @(posedge clk_1x) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$fatal(1, "Timeout");
		end
	end

	// Stop as soon as the bound checker has seen a failure
	always @(posedge clk_1x) begin
		if (loader_top_inst.loader_assertions_inst.fail_count != 0)
			fail_run("A handshake assertion in the bound checker failed");
	end

	// ==============================
	// Checks
	// ==============================
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_wr(input string name, input ram_wr_t exp, input ram_wr_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_media(input string name, input media_status_t exp,
			input media_status_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %s expected %b actual %b", name, exp, act));
	endtask

	// Looks on falling edges where registered outputs are settled
	task automatic wait_strobe(input wait_e which, input string what);
		logic seen;
		int   n;
		seen = 1'b0;
		n = 0;
		while (!seen) begin
			@(negedge clk_1x);
			case (which)
				w_ram_req:  seen = ram_wr_req;
				w_core_ack: seen = core_wr_ack;
				w_wait_low: seen = !dl_wait;
				w_exe:      seen = exe_loaded;
				w_card1:    seen = card1_load;
				w_save:     seen = card_save;
				w_hold:     seen = core_hold;
				default:    seen = !core_hold;
			endcase
			n++;
			if (!seen && n >= WAIT_LIMIT)
				fail_run($sformatf("%s never arrived within %0d cycles", what, WAIT_LIMIT));
		end
	endtask

	// RAM offset per download index
	function automatic logic [`LOADER_ADDR_W-1:0] host_base(input logic [7:0] index);
		if (index == `LOADER_IDX_BIOS)
			return `LOADER_ADDR_W'(`LOADER_BIOS_BASE);
		else if (index == `LOADER_IDX_EXE)
			return `LOADER_ADDR_W'(`LOADER_EXE_BASE);
		return `LOADER_ADDR_W'(`LOADER_CD_BASE);
	endfunction

	function automatic row_t make_row(input op_e op, input logic [7:0] index,
			input logic [26:0] addr, input logic [31:0] data, input logic [63:0] size,
			input logic [3:0] sel);
		return {op, index, addr, data, size, sel};
	endfunction

	// ==============================
	// Row handlers
	// ==============================
	task automatic download_word(input row_t r, input string name);
		ram_wr_t exp;
		if (!dl_on) begin
			@(posedge clk_1x);
			#2;
			dl_index  = r.index;
			dl_active = 1'b1;
			dl_on     = 1'b1;
			wait_strobe(w_hold, "core_hold at download start");
		end
		exp.addr = r.addr + host_base(r.index);
		exp.data = r.data;
		exp.be   = 4'hf;
		@(posedge clk_1x);
		#2;
		dl_wr   = 1'b1;
		dl_beat = {r.addr, r.data[15:0]};
		@(posedge clk_1x);
		#2;
		dl_beat        = {r.addr + 27'd2, r.data[31:16]};
		last_host_addr = r.addr + 27'd2;
		@(posedge clk_1x);
		#2;
		dl_wr = 1'b0;
		wait_strobe(w_ram_req, "ram_wr_req for the download word");
		check_wr(name, exp, ram_wr);
		check_bit({name, " dl_wait"}, 1'b1, dl_wait);
		wait_strobe(w_wait_low, "dl_wait release after the acknowledge");
	endtask

	task automatic core_write(input row_t r, input string name);
		ram_wr_t req;
		req.addr = r.addr;
		req.data = $urandom;
		req.be   = r.sel;
		@(posedge clk_1x);
		#2;
		core_wr  = 1'b1;
		core_req = req;
		@(posedge clk_1x);
		#2;
		core_wr = 1'b0;
		if (dl_on) begin
			// Download owns the port so nothing may come out
			repeat (6) begin
				@(negedge clk_1x);
				check_bit({name, " ram_wr_req"}, 1'b0, ram_wr_req);
				check_bit({name, " core_wr_ack"}, 1'b0, core_wr_ack);
			end
		end else begin
			wait_strobe(w_ram_req, "ram_wr_req for the core write");
			check_wr(name, req, ram_wr);
			wait_strobe(w_core_ack, "core_wr_ack");
		end
	endtask

	task automatic mount_image(input row_t r, input string name);
		@(posedge clk_1x);
		#2;
		img_mounted[r.sel[1:0]] = 1'b1;
		img_size = r.size;
		@(posedge clk_1x);
		#2;
		img_mounted = '0;
		@(negedge clk_1x);
		if (r.sel == `LOADER_SLOT_CD) begin
			exp_media.has_cd = (r.size != 0);
			if (r.size != 0) begin
				exp_media.cd_from_sd = 1'b1;
				exp_media.cd_size    = r.size[29:0];
			end
		end else if (r.sel == `LOADER_SLOT_CARD1) begin
			exp_media.card1_present = (r.size != 0);
		end else begin
			exp_media.card2_present = (r.size != 0);
		end
		check_media(name, exp_media, media);
		check_bit({name, " card1_load"}, r.sel == `LOADER_SLOT_CARD1 && r.size != 0, card1_load);
		check_bit({name, " card2_load"}, r.sel == `LOADER_SLOT_CARD2 && r.size != 0, card2_load);
	endtask

	task automatic end_download(input string name);
		@(posedge clk_1x);
		#2;
		dl_active = 1'b0;
		dl_on     = 1'b0;
		if (dl_index == `LOADER_IDX_EXE) begin
			wait_strobe(w_exe, "exe_loaded at the end of the exe download");
		end else if (dl_index[5:0] == `LOADER_IDX_CD) begin
			// Media follows 3 cycles after the download ends
			repeat (3) @(posedge clk_1x);
			@(negedge clk_1x);
			exp_media.has_cd     = 1'b1;
			exp_media.cd_from_sd = 1'b0;
			exp_media.cd_size    = 30'(last_host_addr);
			check_media(name, exp_media, media);
		end
		wait_strobe(w_hold_low, "core_hold release at download end");
		check_bit({name, " dl_wait"}, 1'b0, dl_wait);
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		op_e   cur_op;
		string name;
		void'($urandom(32'hf89d));
		arst_n         = 1'b1;
		dl_active      = 1'b0;
		dl_index       = '0;
		dl_wr          = 1'b0;
		dl_beat        = '0;
		core_wr        = 1'b0;
		core_req       = '0;
		img_mounted    = '0;
		img_size       = '0;
		user_req       = '0;
		ram_wr_ack     = 1'b0;
		dl_on          = 1'b0;
		exp_media      = '0;
		last_host_addr = '0;

		rows[0]  = make_row(op_dl_word, 8'd0, 27'h0, 32'hcafe_0123, 64'd0, 4'd0);
		rows[1]  = make_row(op_dl_end, 8'd0, 27'h0, 32'h0, 64'd0, 4'd0);
		rows[2]  = make_row(op_core_wr, 8'd0, 27'h1000, 32'h0, 64'd0, 4'b0110);
		rows[3]  = make_row(op_dl_word, 8'd1, 27'h0, 32'h1357_9bdf, 64'd0, 4'd0);
		rows[4]  = make_row(op_core_wr, 8'd0, 27'h2000, 32'h0, 64'd0, 4'hf);
		rows[5]  = make_row(op_dl_word, 8'd1, 27'h8, 32'h2468_ace0, 64'd0, 4'd0);
		rows[6]  = make_row(op_dl_end, 8'd0, 27'h0, 32'h0, 64'd0, 4'd0);
		rows[7]  = make_row(op_dl_word, 8'h42, 27'h4, 32'hdead_beef, 64'd0, 4'd0);
		rows[8]  = make_row(op_dl_end, 8'd0, 27'h0, 32'h0, 64'd0, 4'd0);
		rows[9]  = make_row(op_mount, 8'd0, 27'h0, 32'h0, 64'h1_2345_6789, 4'd1);
		rows[10] = make_row(op_mount, 8'd0, 27'h0, 32'h0, 64'd0, 4'd1);
		rows[11] = make_row(op_mount, 8'd0, 27'h0, 32'h0, 64'h2_0000, 4'd2);
		rows[12] = make_row(op_mount, 8'd0, 27'h0, 32'h0, 64'h2_0000, 4'd3);
		rows[13] = make_row(op_load, 8'd0, 27'h0, 32'h0, 64'd0, 4'd0);
		rows[14] = make_row(op_save, 8'd0, 27'h0, 32'h0, 64'd0, 4'd0);
		rows[15] = make_row(op_save, 8'd0, 27'h0, 32'h0, 64'd0, 4'd1);

		#1 arst_n = 1'b0;
		repeat (8) @(posedge clk_1x);
		#2 arst_n = 1'b1;
		@(negedge clk_1x);
		check_media("reset media", '0, media);

		for (int i = 0; i < N_ROWS; i++) begin
			cur_op = rows[i].op;
			name   = $sformatf("row %0d %s", i, cur_op.name());
			case (cur_op)
				op_dl_word: download_word(rows[i], name);
				op_core_wr: core_write(rows[i], name);
				op_mount:   mount_image(rows[i], name);
				op_dl_end:  end_download(name);
				op_load: begin
					user_req.load_req = 1'b1;
					wait_strobe(w_card1, "card1_load after the load request");
					check_bit({name, " card2_load"}, 1'b1, card2_load);
				end
				default: begin
					// Autosave arms before the menu opening triggers the save
					if (rows[i].sel[0]) begin
						user_req.autosave = 1'b1;
						@(posedge clk_1x);
						#2 user_req.osd_open = 1'b1;
					end else begin
						user_req.save_req = 1'b1;
					end
					wait_strobe(w_save, "card_save after the save request");
				end
			endcase
			@(posedge clk_1x);
			#2 user_req = '0;
		end

		repeat (4) @(posedge clk_1x);
		if (loader_top_inst.loader_assertions_inst.fail_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("Finished with errors");
			$fatal(1, "Checks failed");
		end
	end

endmodule

//--- list.f
+incdir+logic
logic/loader_pkg.sv
logic/download_packer.sv
logic/ram_write_mux.sv
logic/media_tracker.sv
logic/loader_top.sv
testbench/loader_assertions.sv
testbench/loader_tb.sv
